// ==== ucpd_defines.svh ====
// --------------------
// UCPD register map offsets, bus widths,
// SR bit positions and timing constants
// --------------------
`ifndef UCPD_DEFINES_SVH
`define UCPD_DEFINES_SVH

// Bus geometry
`define UCPD_DW           32
`define UCPD_AW           6

// Word offsets (byte map divided by four)
`define UCPD_CFG1_OS      6'd0   // 0x00
`define UCPD_CR_OS        6'd3   // 0x0c
`define UCPD_IMR_OS       6'd4   // 0x10
`define UCPD_SR_OS        6'd5   // 0x14
`define UCPD_ICR_OS       6'd6   // 0x18

`define UCPD_SYNC_STAGES  2
`define UCPD_ACK_LAT      1      // Request edge to ack, in cycles

// --------------------
// SR bit positions
`define UCPD_SR_TXIS        0
`define UCPD_SR_TXMSGDISC   1
`define UCPD_SR_TXMSGSENT   2
`define UCPD_SR_TXMSGABT    3
`define UCPD_SR_HRSTDISC    4
`define UCPD_SR_HRSTSENT    5
`define UCPD_SR_TXUND       6
`define UCPD_SR_RXNE        8
`define UCPD_SR_RXORDDET    9
`define UCPD_SR_RXHRSTDET   10
`define UCPD_SR_RXOVR       11
`define UCPD_SR_RXMSGEND    12
`define UCPD_SR_RXERR       13
`define UCPD_SR_TYPECEVT1   14
`define UCPD_SR_TYPECEVT2   15
`define UCPD_SR_VSTATE_CC1  16     // Field LSB, 2 bits wide
`define UCPD_SR_VSTATE_CC2  18     // Field LSB, 2 bits wide

`define UCPD_SR_W1C_MASK    32'h0000_ff7f

`endif

// ==== ucpd_reg_pkg.sv ====
// --------------------
// Register map types: CFG1 and CR layouts,
// write strobes and the Wishbone request
// --------------------
`default_nettype none

`include "ucpd_defines.svh"

package ucpd_reg_pkg;

  // Configuration register 1
  typedef struct packed {
    logic       ucpden;        // 31
    logic [1:0] rsvd_30_29;
    logic [8:0] rx_ordset_en;  // 28:20
    logic [2:0] psc_usbpdclk;  // 19:17
    logic       rsvd_16;
    logic [4:0] transwin;      // 15:11
    logic [4:0] ifrgap;        // 10:6
    logic [5:0] hbitclkdiv;    // 5:0
  } cfg1_t;

  // Control register
  typedef struct packed {
    logic [9:0] rsvd_31_22;
    logic       cc2tcdis;      // 21
    logic       cc1tcdis;      // 20
    logic [7:0] rsvd_19_12;
    logic [1:0] ccenable;      // 11:10
    logic       anamode;       // 9
    logic [1:0] anasubmode;    // 8:7
    logic       phyccsel;      // 6
    logic       phyrxen;       // 5
    logic       rsvd_4;
    logic       txhrst;        // 3
    logic       txsend;        // 2
    logic [1:0] txmode;        // 1:0
  } cr_t;

  // Single-cycle write strobes from the bus slave
  typedef struct packed {
    logic                cfg1_we;
    logic                cr_we;
    logic                imr_we;
    logic                icr_we;
    logic [`UCPD_DW-1:0] wdata;
  } reg_wr_t;

  // Wishbone classic request, full-word accesses only
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`UCPD_AW-1:0] adr;
    logic [`UCPD_DW-1:0] dat_w;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== ucpd_phy_pkg.sv ====
// --------------------
// PHY side types: status vectors, comparators,
// voltage state, analog control and link config
// --------------------
`default_nettype none

package ucpd_phy_pkg;

  // Transmit status, same order as SR bits 6:0
  typedef struct packed {
    logic txund;
    logic hrstsent;
    logic hrstdisc;
    logic txmsgabt;
    logic txmsgsent;
    logic txmsgdisc;
    logic txis;
  } tx_status_t;

  // Receive status, same order as SR bits 13:8
  typedef struct packed {
    logic rxerr;
    logic rxmsgend;
    logic rxovr;
    logic rxhrstdet;
    logic rxorddet;
    logic rxne;
  } rx_status_t;

  // Thermometer coded comparator levels
  typedef struct packed {
    logic [2:0] cc2;
    logic [2:0] cc1;
  } cc_comp_t;

  typedef logic [1:0] vstate_t;

  typedef struct packed {
    logic [1:0] phy_en;
    logic       set_c500;
    logic       set_c1500;
    logic       set_c3000;
    logic       set_pd;
    logic       source_en;
    logic       phy_rx_en;
    logic       cc1_det_en;
    logic       cc2_det_en;
    logic       phy_cc1_com;
    logic       phy_cc2_com;
  } analog_ctrl_t;

  // Timing fields from CFG1 plus transmit requests from CR
  typedef struct packed {
    logic [8:0] rx_ordset_en;
    logic [2:0] psc_usbpdclk;
    logic [4:0] transwin;
    logic [4:0] ifrgap;
    logic [5:0] hbitclkdiv;
    logic [1:0] tx_mode;
    logic       transmit_en;
    logic       tx_hrst;
  } link_cfg_t;

endpackage

`default_nettype wire

// ==== ucpd_wb_slave.sv ====
// --------------------
// Wishbone classic slave with address decode,
// write strobes, one-cycle ack and read mux
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module ucpd_wb_slave (
  input  logic                  pclk,
  input  logic                  presetn,
  input  ucpd_reg_pkg::wb_req_t wb_req,
  output logic                  wb_ack,
  output logic [`UCPD_DW-1:0]   wb_dat_r,
  output ucpd_reg_pkg::reg_wr_t reg_wr,
  input  logic [`UCPD_DW-1:0]   cfg1_rd,
  input  logic [`UCPD_DW-1:0]   cr_rd,
  input  logic [`UCPD_DW-1:0]   imr_rd,
  input  logic [`UCPD_DW-1:0]   sr_rd
);

  logic                req;     // New request on this edge
  logic                wr_acc;
  logic [`UCPD_DW-1:0] rd_mux;

  assign req    = wb_req.cyc & wb_req.stb & ~wb_ack;
  assign wr_acc = req & wb_req.we;

  // --------------------
  // Write strobes, committed on the ack edge
  always_comb
  begin
    reg_wr.cfg1_we = wr_acc && (wb_req.adr == `UCPD_CFG1_OS);
    reg_wr.cr_we   = wr_acc && (wb_req.adr == `UCPD_CR_OS);
    reg_wr.imr_we  = wr_acc && (wb_req.adr == `UCPD_IMR_OS);
    reg_wr.icr_we  = wr_acc && (wb_req.adr == `UCPD_ICR_OS);
    reg_wr.wdata   = wb_req.dat_w;
  end

  // Read mux, ICR and holes read as zero
  always_comb
  begin
    case (wb_req.adr)
      `UCPD_CFG1_OS: rd_mux = cfg1_rd;
      `UCPD_CR_OS:   rd_mux = cr_rd;
      `UCPD_IMR_OS:  rd_mux = imr_rd;
      `UCPD_SR_OS:   rd_mux = sr_rd;
      default:       rd_mux = '0;
    endcase
  end

  // --------------------
  // Ack for one cycle per request
  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      wb_ack <= 1'b0;
    else
      wb_ack <= req;
  end

  always_ff @(posedge pclk)
  begin
    if (req && !wb_req.we)
      wb_dat_r <= rd_mux;  // Held until the next read
  end

endmodule

`default_nettype wire

// ==== ucpd_ctrl_regs.sv ====
// --------------------
// CFG1, CR and IMR storage with enable rules
// and the analog and link control decode
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module ucpd_ctrl_regs (
  input  logic                       pclk,
  input  logic                       presetn,
  input  ucpd_reg_pkg::reg_wr_t      reg_wr,
  input  logic                       hrst_evt,
  input  logic                       txhrst_clr,
  input  logic                       txsend_clr,
  output logic [`UCPD_DW-1:0]        cfg1_rd,
  output logic [`UCPD_DW-1:0]        cr_rd,
  output logic [`UCPD_DW-1:0]        imr_rd,
  output logic                       ucpden,
  output ucpd_phy_pkg::analog_ctrl_t analog_ctrl,
  output ucpd_phy_pkg::link_cfg_t    link_cfg
);

  import ucpd_reg_pkg::*;

  cfg1_t               cfg1_q;
  cr_t                 cr_q;
  logic [`UCPD_DW-1:0] imr_q;

  assign ucpden = cfg1_q.ucpden;

  // --------------------
  // CFG1: bit 31 set only enables, else load the fields
  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      cfg1_q <= '0;
    else if (hrst_evt)
      cfg1_q.ucpden <= 1'b0;       // Hard reset sent
    else if (reg_wr.cfg1_we)
    begin
      if (reg_wr.wdata[31])
        cfg1_q.ucpden <= 1'b1;
      else
        cfg1_q[30:0] <= reg_wr.wdata[30:0];
    end
  end

  // CR is held clear while the block is off
  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      cr_q <= '0;
    else if (!cfg1_q.ucpden)
      cr_q <= '0;
    else if (reg_wr.cr_we)
      cr_q <= reg_wr.wdata;
    else if (txhrst_clr)
      cr_q.txhrst <= 1'b0;
    else if (txsend_clr)
      cr_q.txsend <= 1'b0;
  end

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      imr_q <= '0;
    else if (reg_wr.imr_we && cfg1_q.ucpden)
      imr_q <= reg_wr.wdata;
  end

  assign cfg1_rd = cfg1_q;
  assign cr_rd   = cr_q;
  assign imr_rd  = imr_q;

  // --------------------
  // Analog front end, all off while disabled
  always_comb
  begin
    analog_ctrl.phy_en      = cr_q.ccenable & {2{ucpden}};
    analog_ctrl.set_c500    = ucpden & (cr_q.anasubmode == 2'd1);
    analog_ctrl.set_c1500   = ucpden & (cr_q.anasubmode == 2'd2);
    analog_ctrl.set_c3000   = ucpden & (cr_q.anasubmode == 2'd3);
    analog_ctrl.set_pd      = ucpden & cr_q.anamode;    // Sink pull-down
    analog_ctrl.source_en   = ucpden & ~cr_q.anamode;
    analog_ctrl.phy_rx_en   = ucpden & cr_q.phyrxen;
    analog_ctrl.cc1_det_en  = ucpden & ~cr_q.cc1tcdis;
    analog_ctrl.cc2_det_en  = ucpden & ~cr_q.cc2tcdis;
    analog_ctrl.phy_cc1_com = ucpden & ~cr_q.phyccsel;
    analog_ctrl.phy_cc2_com = ucpden & cr_q.phyccsel;
  end

  always_comb
  begin
    link_cfg.rx_ordset_en = cfg1_q.rx_ordset_en;
    link_cfg.psc_usbpdclk = cfg1_q.psc_usbpdclk;
    link_cfg.transwin     = cfg1_q.transwin;
    link_cfg.ifrgap       = cfg1_q.ifrgap;
    link_cfg.hbitclkdiv   = cfg1_q.hbitclkdiv;
    link_cfg.tx_mode      = cr_q.txmode;
    link_cfg.transmit_en  = cr_q.txsend;
    link_cfg.tx_hrst      = cr_q.txhrst;
  end

endmodule

`default_nettype wire

// ==== ucpd_event_sync.sv ====
// --------------------
// Flop chain synchronizer with per-bit
// rising edge pulses, any packed payload
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module ucpd_event_sync #(
  parameter type payload_t = logic [0:0]
) (
  input  logic     pclk,
  input  logic     presetn,
  input  payload_t async_in,
  output payload_t rise
);

  localparam int LAST = `UCPD_SYNC_STAGES - 1;

  payload_t [LAST:0] sync_q;  // Index LAST is the synced output
  payload_t          sync_d;  // One cycle behind the synced output

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      sync_q <= '0;
      sync_d <= '0;
    end
    else
    begin
      sync_q <= {sync_q[LAST-1:0], async_in};
      sync_d <= sync_q[LAST];
    end
  end

  assign rise = payload_t'(sync_q[LAST] & ~sync_d);

endmodule

`default_nettype wire

// ==== ucpd_cc_monitor.sv ====
// --------------------
// CC comparator sync, Type-C voltage state
// decode and change events
// --------------------
`timescale 1ns/1ps
`default_nettype none

module ucpd_cc_monitor (
  input  logic                   pclk,
  input  logic                   presetn,
  input  ucpd_phy_pkg::cc_comp_t cc_comp,
  input  logic                   source_en,
  output ucpd_phy_pkg::vstate_t  vstate_cc1,
  output ucpd_phy_pkg::vstate_t  vstate_cc2,
  output logic                   cc1_evt,
  output logic                   cc2_evt
);

  import ucpd_phy_pkg::*;

  cc_comp_t comp_s0;
  cc_comp_t comp_s1;
  vstate_t  prev_cc1;
  vstate_t  prev_cc2;

  // Source and sink use different thresholds
  function automatic vstate_t decode_level(input logic [2:0] code, input logic src);
    vstate_t lvl;
    if (src)
      case (code)
        3'b001:  lvl = 2'd0;
        3'b011:  lvl = 2'd1;
        3'b111:  lvl = 2'd2;
        default: lvl = 2'd3;
      endcase
    else
      case (code)
        3'b001:  lvl = 2'd1;
        3'b011:  lvl = 2'd2;
        3'b111:  lvl = 2'd3;
        default: lvl = 2'd0;  // Also covers 000
      endcase
    return lvl;
  endfunction

  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
    begin
      comp_s0    <= '0;
      comp_s1    <= '0;
      vstate_cc1 <= '0;
      vstate_cc2 <= '0;
      prev_cc1   <= '0;
      prev_cc2   <= '0;
    end
    else
    begin
      comp_s0    <= cc_comp;
      comp_s1    <= comp_s0;
      vstate_cc1 <= decode_level(comp_s1.cc1, source_en);
      vstate_cc2 <= decode_level(comp_s1.cc2, source_en);
      prev_cc1   <= vstate_cc1;
      prev_cc2   <= vstate_cc2;
    end
  end

  // High for the one cycle before prev catches up
  assign cc1_evt = (vstate_cc1 != prev_cc1);
  assign cc2_evt = (vstate_cc2 != prev_cc2);

endmodule

`default_nettype wire

// ==== ucpd_status_reg.sv ====
// --------------------
// SR flags with ICR clear, vstate fields
// and the masked interrupt
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module ucpd_status_reg (
  input  logic                     pclk,
  input  logic                     presetn,
  input  ucpd_phy_pkg::tx_status_t tx_rise,
  input  ucpd_phy_pkg::rx_status_t rx_rise,
  input  ucpd_phy_pkg::vstate_t    vstate_cc1,
  input  ucpd_phy_pkg::vstate_t    vstate_cc2,
  input  logic                     cc1_evt,
  input  logic                     cc2_evt,
  input  logic                     icr_we,
  input  logic [`UCPD_DW-1:0]      wdata,
  input  logic [`UCPD_DW-1:0]      imr,
  output logic [`UCPD_DW-1:0]      sr_rd,
  output logic                     ucpd_intr
);

  logic [`UCPD_DW-1:0] set_vec;  // Event pulses in SR layout
  logic [`UCPD_DW-1:0] clr_vec;
  logic [`UCPD_DW-1:0] vst_vec;
  logic [`UCPD_DW-1:0] sr_q;

  // --------------------
  always_comb
  begin
    set_vec = '0;
    set_vec[`UCPD_SR_TXIS +: $bits(tx_rise)] = tx_rise;
    set_vec[`UCPD_SR_RXNE +: $bits(rx_rise)] = rx_rise;
    set_vec[`UCPD_SR_TYPECEVT1]              = cc1_evt;
    set_vec[`UCPD_SR_TYPECEVT2]              = cc2_evt;
  end

  always_comb
  begin
    vst_vec = '0;
    vst_vec[`UCPD_SR_VSTATE_CC1 +: 2] = vstate_cc1;
    vst_vec[`UCPD_SR_VSTATE_CC2 +: 2] = vstate_cc2;
  end

  // Write one to clear, flag bits only
  assign clr_vec = icr_we ? (wdata & `UCPD_SR_W1C_MASK) : '0;

  // Clear wins over a same-cycle set
  always_ff @(posedge pclk or negedge presetn)
  begin
    if (!presetn)
      sr_q <= '0;
    else
      sr_q <= (((sr_q | set_vec) & ~clr_vec) & `UCPD_SR_W1C_MASK) | vst_vec;
  end

  assign sr_rd     = sr_q;
  assign ucpd_intr = |(sr_q & imr);

endmodule

`default_nettype wire

// ==== ucpd_top.sv ====
// --------------------
// UCPD register block top level
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module ucpd_top (
  input  logic                       pclk,
  input  logic                       presetn,
  input  ucpd_reg_pkg::wb_req_t      wb_req,
  output logic                       wb_ack,
  output logic [`UCPD_DW-1:0]        wb_dat_r,
  input  ucpd_phy_pkg::tx_status_t   tx_status,
  input  ucpd_phy_pkg::rx_status_t   rx_status,
  input  ucpd_phy_pkg::cc_comp_t     cc_comp,
  input  logic                       txhrst_clr,
  input  logic                       txsend_clr,
  output ucpd_phy_pkg::analog_ctrl_t analog_ctrl,
  output ucpd_phy_pkg::link_cfg_t    link_cfg,
  output logic                       ucpd_intr
);

  import ucpd_reg_pkg::*;
  import ucpd_phy_pkg::*;

  reg_wr_t             reg_wr;
  logic [`UCPD_DW-1:0] cfg1_rd;
  logic [`UCPD_DW-1:0] cr_rd;
  logic [`UCPD_DW-1:0] imr_rd;
  logic [`UCPD_DW-1:0] sr_rd;
  logic                ucpden;
  tx_status_t          tx_rise;
  rx_status_t          rx_rise;
  vstate_t             vstate_cc1;
  vstate_t             vstate_cc2;
  logic                cc1_evt;
  logic                cc2_evt;

  ucpd_wb_slave u_wb_slave (
    .pclk     (pclk),
    .presetn  (presetn),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .reg_wr   (reg_wr),
    .cfg1_rd  (cfg1_rd),
    .cr_rd    (cr_rd),
    .imr_rd   (imr_rd),
    .sr_rd    (sr_rd)
  );

  ucpd_ctrl_regs u_ctrl_regs (
    .pclk        (pclk),
    .presetn     (presetn),
    .reg_wr      (reg_wr),
    .hrst_evt    (tx_rise.hrstsent),  // Hard reset sent disables the block
    .txhrst_clr  (txhrst_clr),
    .txsend_clr  (txsend_clr),
    .cfg1_rd     (cfg1_rd),
    .cr_rd       (cr_rd),
    .imr_rd      (imr_rd),
    .ucpden      (ucpden),
    .analog_ctrl (analog_ctrl),
    .link_cfg    (link_cfg)
  );

  ucpd_event_sync #(.payload_t(tx_status_t)) u_tx_sync (
    .pclk     (pclk),
    .presetn  (presetn),
    .async_in (tx_status),
    .rise     (tx_rise)
  );

  ucpd_event_sync #(.payload_t(rx_status_t)) u_rx_sync (
    .pclk     (pclk),
    .presetn  (presetn),
    .async_in (rx_status),
    .rise     (rx_rise)
  );

  ucpd_cc_monitor u_cc_monitor (
    .pclk       (pclk),
    .presetn    (presetn),
    .cc_comp    (cc_comp),
    .source_en  (analog_ctrl.source_en),
    .vstate_cc1 (vstate_cc1),
    .vstate_cc2 (vstate_cc2),
    .cc1_evt    (cc1_evt),
    .cc2_evt    (cc2_evt)
  );

  ucpd_status_reg u_status_reg (
    .pclk       (pclk),
    .presetn    (presetn),
    .tx_rise    (tx_rise),
    .rx_rise    (rx_rise),
    .vstate_cc1 (vstate_cc1),
    .vstate_cc2 (vstate_cc2),
    .cc1_evt    (cc1_evt),
    .cc2_evt    (cc2_evt),
    .icr_we     (reg_wr.icr_we),
    .wdata      (reg_wr.wdata),
    .imr        (imr_rd),
    .sr_rd      (sr_rd),
    .ucpd_intr  (ucpd_intr)
  );

endmodule

`default_nettype wire

// ==== tb_ucpd_asserts.sv ====
// --------------------
// Concurrent checks on the UCPD top level for
// bus ack, analog gating, interrupt and flag timing
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module tb_ucpd_asserts (
  input logic                       pclk,
  input logic                       presetn,
  input ucpd_reg_pkg::wb_req_t      wb_req,
  input logic                       wb_ack,
  input logic                       ucpden,
  input ucpd_phy_pkg::analog_ctrl_t analog_ctrl,
  input logic                       ucpd_intr,
  input logic [`UCPD_DW-1:0]        sr_rd,
  input logic [`UCPD_DW-1:0]        imr_rd,
  input logic                       icr_we,
  input ucpd_phy_pkg::tx_status_t   tx_status,
  input ucpd_phy_pkg::rx_status_t   rx_status
);

  int unsigned  fail_cnt = 0;
  logic [13:0]  ext_bits;    // External status in SR layout, bit 7 unused

  assign ext_bits   = {rx_status, 1'b0, tx_status};

  // --------------------
  a_ack_single: assert property (@(posedge pclk) disable iff (!presetn)
    wb_ack |=> !wb_ack)
  else
  begin
    $error("wb_ack stayed high for more than one cycle");
    fail_cnt++;
  end

  a_ack_req: assert property (@(posedge pclk) disable iff (!presetn)
    wb_ack |-> $past(wb_req.cyc && wb_req.stb && !wb_ack))
  else
  begin
    $error("wb_ack rose without a pending request");
    fail_cnt++;
  end

  // Front end stays off while the block is disabled
  a_analog_off: assert property (@(posedge pclk) disable iff (!presetn)
    !ucpden |-> (analog_ctrl == '0))
  else
  begin
    $error("analog_ctrl active while ucpden is low");
    fail_cnt++;
  end

  a_intr: assert property (@(posedge pclk) disable iff (!presetn)
    ucpd_intr == |(sr_rd & imr_rd))
  else
  begin
    $error("ucpd_intr differs from the masked OR of SR and IMR");
    fail_cnt++;
  end

  // Rise sampled at edge k shows in SR at edge k+3 unless cleared on k+2
  a_flag_set: assert property (@(posedge pclk) disable iff (!presetn)
    !$past(icr_we) |->
      ((($past(ext_bits, 3) & ~$past(ext_bits, 4)) & ~sr_rd[13:0]) == 14'd0))
  else
  begin
    $error("status input rose but its SR flag was not set three edges later");
    fail_cnt++;
  end

endmodule

bind ucpd_top tb_ucpd_asserts u_asserts (
  .pclk        (pclk),
  .presetn     (presetn),
  .wb_req      (wb_req),
  .wb_ack      (wb_ack),
  .ucpden      (ucpden),
  .analog_ctrl (analog_ctrl),
  .ucpd_intr   (ucpd_intr),
  .sr_rd       (sr_rd),
  .imr_rd      (imr_rd),
  .icr_we      (reg_wr.icr_we),
  .tx_status   (tx_status),
  .rx_status   (rx_status)
);

`default_nettype wire

// ==== tb_ucpd.sv ====
// --------------------
// Testbench for the UCPD register block with
// Wishbone tasks, stimulus and value checks
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ucpd_defines.svh"

module tb_ucpd;

  import ucpd_reg_pkg::*;
  import ucpd_phy_pkg::*;

  logic                pclk;
  logic                presetn;
  wb_req_t             wb_req;
  logic                wb_ack;
  logic [`UCPD_DW-1:0] wb_dat_r;
  tx_status_t          tx_status;
  rx_status_t          rx_status;
  cc_comp_t            cc_comp;
  logic                txhrst_clr;
  logic                txsend_clr;
  analog_ctrl_t        analog_ctrl;
  link_cfg_t           link_cfg;
  logic                ucpd_intr;

  integer      seed;
  int          errors;
  int          checks;
  int          afail;
  int          pos;
  int          n;
  int          m;
  int          code;
  logic        src;
  logic [31:0] rd;
  logic [31:0] cfg;
  logic [31:0] cr;
  logic [31:0] flag;
  logic [2:0]  c1;
  logic [2:0]  c2;
  logic [1:0]  e1;
  logic [1:0]  e2;
  logic [1:0]  prev1;
  logic [1:0]  prev2;

  ucpd_top UUT (
    .pclk        (pclk),
    .presetn     (presetn),
    .wb_req      (wb_req),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .tx_status   (tx_status),
    .rx_status   (rx_status),
    .cc_comp     (cc_comp),
    .txhrst_clr  (txhrst_clr),
    .txsend_clr  (txsend_clr),
    .analog_ctrl (analog_ctrl),
    .link_cfg    (link_cfg),
    .ucpd_intr   (ucpd_intr)
  );

  initial
  begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // --------------------
  task automatic check_val(input string name, input logic [31:0] expv,
                           input logic [31:0] actv);
    checks++;
    if (actv !== expv)
    begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expv, actv);
    end
  endtask

  // One classic cycle, request held until ack is seen
  task automatic wb_access(input logic we, input logic [`UCPD_AW-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cnt;
    cnt = 0;
    @(posedge pclk);
    wb_req.cyc   <= 1'b1;
    wb_req.stb   <= 1'b1;
    wb_req.we    <= we;
    wb_req.adr   <= adr;
    wb_req.dat_w <= wdata;
    @(posedge pclk);
    while (!wb_ack && (cnt < 16))
    begin
      @(posedge pclk);
      cnt++;
    end
    if (!wb_ack)
    begin
      errors++;
      $display("Wishbone ack never arrived for address %0d", adr);
    end
    rdata = wb_dat_r;
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [`UCPD_AW-1:0] adr, input logic [31:0] data);
    logic [31:0] dummy_rd;
    wb_access(1'b1, adr, data, dummy_rd);
  endtask

  task automatic wb_read(input logic [`UCPD_AW-1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'd0, data);
  endtask

  // Re-read a register until the masked value matches or the tries run out
  task automatic poll_reg(input string name, input logic [`UCPD_AW-1:0] adr,
                          input logic [31:0] mask, input logic [31:0] expv,
                          output logic [31:0] val);
    int tries;
    tries = 0;
    wb_read(adr, val);
    while (((val & mask) !== expv) && (tries < 12))
    begin
      wb_read(adr, val);
      tries++;
    end
    check_val(name, expv, val & mask);
  endtask

  task automatic pulse_clr(input logic hrst);
    @(posedge pclk);
    if (hrst)
      txhrst_clr <= 1'b1;
    else
      txsend_clr <= 1'b1;
    @(posedge pclk);
    txhrst_clr <= 1'b0;
    txsend_clr <= 1'b0;
    @(posedge pclk);
  endtask

  // --------------------
  // Expected values from the register rules
  function automatic logic [31:0] analog_from_cr(input logic [31:0] c);
    return {20'd0, c[11:10], c[8:7] == 2'd1, c[8:7] == 2'd2, c[8:7] == 2'd3,
            c[9], ~c[9], c[5], ~c[20], ~c[21], ~c[6], c[6]};
  endfunction

  function automatic logic [31:0] link_from(input logic [31:0] f, input logic [31:0] c);
    return {f[28:20], f[19:17], f[15:11], f[10:6], f[5:0], c[1:0], c[2], c[3]};
  endfunction

  function automatic logic [1:0] table_vstate(input logic [2:0] cc, input logic source);
    logic [1:0] v;
    if (source)
      v = (cc == 3'b001) ? 2'd0 : (cc == 3'b011) ? 2'd1 : (cc == 3'b111) ? 2'd2 : 2'd3;
    else
      v = (cc == 3'b001) ? 2'd1 : (cc == 3'b011) ? 2'd2 : (cc == 3'b111) ? 2'd3 : 2'd0;
    return v;
  endfunction

  initial
  begin
    seed       = 8;
    errors     = 0;
    checks     = 0;
    presetn    = 1'b0;
    wb_req     = '0;
    tx_status  = '0;
    rx_status  = '0;
    cc_comp    = '0;
    txhrst_clr = 1'b0;
    txsend_clr = 1'b0;
    repeat (8) @(posedge pclk);
    presetn <= 1'b1;

    // Reset values
    wb_read(`UCPD_CFG1_OS, rd);
    check_val("reset_cfg1", 32'd0, rd);
    wb_read(`UCPD_CR_OS, rd);
    check_val("reset_cr", 32'd0, rd);
    wb_read(`UCPD_IMR_OS, rd);
    check_val("reset_imr", 32'd0, rd);
    wb_read(`UCPD_SR_OS, rd);
    check_val("reset_sr", 32'd0, rd);
    check_val("reset_analog", 32'd0, {20'd0, analog_ctrl});
    check_val("reset_link", 32'd0, link_cfg);
    check_val("reset_intr", 32'd0, {31'd0, ucpd_intr});

    // --------------------
    // Enable protocol and analog decode
    wb_write(`UCPD_CR_OS, $random(seed));
    wb_read(`UCPD_CR_OS, rd);
    check_val("cr_disabled", 32'd0, rd);
    wb_write(`UCPD_IMR_OS, 32'hffff_ffff);
    wb_read(`UCPD_IMR_OS, rd);
    check_val("imr_disabled", 32'd0, rd);
    cfg = $random(seed) & 32'h7fff_ffff;
    wb_write(`UCPD_CFG1_OS, cfg);
    wb_read(`UCPD_CFG1_OS, rd);
    check_val("cfg1_fields", cfg, rd);
    wb_write(`UCPD_CFG1_OS, 32'h8000_0000 | $random(seed));  // Other bits ignored
    cfg = cfg | 32'h8000_0000;
    wb_read(`UCPD_CFG1_OS, rd);
    check_val("cfg1_enable", cfg, rd);
    cr = $random(seed);
    wb_write(`UCPD_CR_OS, cr);
    wb_read(`UCPD_CR_OS, rd);
    check_val("cr_enabled", cr, rd);
    check_val("analog_decode", analog_from_cr(cr), {20'd0, analog_ctrl});
    check_val("link_cfg", link_from(cfg, cr), link_cfg);

    // --------------------
    // Status flags, IMR gating and ICR clear
    wb_write(`UCPD_IMR_OS, 32'd0);
    for (n = 0; n < 4; n++)
    begin
      pos = {$random(seed)} % 13;
      if (pos >= 7)
        pos = pos + 1;         // RX flags start at bit 8
      if (pos == `UCPD_SR_HRSTSENT)
        pos = `UCPD_SR_TXUND;  // Hard reset is covered at the end
      flag = 32'd1 << pos;
      @(posedge pclk);
      tx_status <= flag[6:0];
      rx_status <= flag[13:8];
      poll_reg($sformatf("flag_set_%0d", pos), `UCPD_SR_OS, flag, flag, rd);
      check_val("intr_masked", 32'd0, {31'd0, ucpd_intr});
      wb_write(`UCPD_IMR_OS, flag);
      check_val("intr_unmasked", 32'd1, {31'd0, ucpd_intr});
      wb_write(`UCPD_ICR_OS, flag);
      wb_read(`UCPD_SR_OS, rd);
      check_val($sformatf("flag_clear_%0d", pos), 32'd0, rd & flag);
      check_val("intr_cleared", 32'd0, {31'd0, ucpd_intr});
      @(posedge pclk);
      tx_status <= '0;
      rx_status <= '0;
      wb_write(`UCPD_IMR_OS, 32'd0);
    end

    // --------------------
    // Comparator decode in source then sink mode
    for (m = 0; m < 2; m++)
    begin
      src = (m == 0);
      @(posedge pclk);
      cc_comp <= '0;
      wb_write(`UCPD_CR_OS, src ? 32'h0000_0000 : 32'h0000_0200);  // anamode
      prev1 = table_vstate(3'b000, src);
      prev2 = prev1;
      poll_reg("vstate_idle", `UCPD_SR_OS, 32'h000f_0000, {12'd0, prev2, prev1, 16'd0}, rd);
      wb_write(`UCPD_ICR_OS, 32'h0000_c000);
      for (code = 0; code < 8; code++)
      begin
        c1 = code[2:0];
        c2 = c1 + 3'd3;
        e1 = table_vstate(c1, src);
        e2 = table_vstate(c2, src);
        @(posedge pclk);
        cc_comp.cc1 <= c1;
        cc_comp.cc2 <= c2;
        poll_reg($sformatf("vstate_%s_%0d", src ? "src" : "snk", code), `UCPD_SR_OS,
                 32'h000f_0000, {12'd0, e2, e1, 16'd0}, rd);
        check_val($sformatf("typecevt_%0d", code), {30'd0, e2 != prev2, e1 != prev1},
                  {30'd0, rd[15:14]});
        wb_write(`UCPD_ICR_OS, 32'h0000_c000);
        prev1 = e1;
        prev2 = e2;
      end
    end

    // --------------------
    // Transmit request clears
    wb_write(`UCPD_CR_OS, 32'h0000_000e);
    check_val("tx_request", 32'd3, {30'd0, link_cfg.transmit_en, link_cfg.tx_hrst});
    pulse_clr(1'b0);
    check_val("txsend_clr", 32'd1, {30'd0, link_cfg.transmit_en, link_cfg.tx_hrst});
    pulse_clr(1'b1);
    check_val("txhrst_clr", 32'd0, {30'd0, link_cfg.transmit_en, link_cfg.tx_hrst});
    wb_read(`UCPD_CR_OS, rd);
    check_val("cr_after_clr", 32'h0000_0002, rd);

    // Hard reset sent drops the enable
    wb_write(`UCPD_CR_OS, $random(seed) | 32'h0000_0c00);
    @(posedge pclk);
    tx_status <= 7'h20;
    poll_reg("hrst_disable", `UCPD_CFG1_OS, 32'hffff_ffff, cfg & 32'h7fff_ffff, rd);
    wb_read(`UCPD_CR_OS, rd);
    check_val("hrst_cr", 32'd0, rd);
    check_val("hrst_analog", 32'd0, {20'd0, analog_ctrl});
    wb_read(`UCPD_SR_OS, rd);
    check_val("hrst_flag", 32'h0000_0020, rd & 32'h0000_0020);
    @(posedge pclk);
    tx_status <= '0;
    repeat (4) @(posedge pclk);

    afail = int'(UUT.u_asserts.fail_cnt);
    $display("Checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, afail);
    if ((errors == 0) && (afail == 0))
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
ucpd_reg_pkg.sv
ucpd_phy_pkg.sv
ucpd_wb_slave.sv
ucpd_ctrl_regs.sv
ucpd_event_sync.sv
ucpd_cc_monitor.sv
ucpd_status_reg.sv
ucpd_top.sv
tb_ucpd_asserts.sv
tb_ucpd.sv

// ==== Makefile ====
# Verilator flow for the UCPD register block

VERILATOR  ?= verilator
TOP        := tb_ucpd
RTL_TOP    := ucpd_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS
LINT_FLAGS := --lint-only --timing -Wall -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
RUN_FLAGS  := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
